//--- run.sh
#!/usr/bin/env bash
# Build the simulation with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module tb_mem_hub \
    -o sim_mem_hub \
    && ./obj_dir/sim_mem_hub > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log

grep -q "TEST FAILED" sim.log \
    && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }

//--- project.f
src/arb_pkg.sv
src/priority_encoder.sv
src/arbiter.sv
src/client_channel.sv
src/shared_mem.sv
src/mem_hub.sv
testbench/tb_mem_hub.sv

//--- testbench/tb_mem_hub.sv
`timescale 1ns/1ns

module tb_mem_hub import arb_pkg::*; ();

    localparam int PORTS      = 4;
    localparam int MAX_TXNS   = 40;   // Upper bound on transactions over all tests
    localparam int TXN_CYCLES = 12;   // Worst case per transaction under full contention
    // Eightfold margin on the transaction budget plus room for reset
    localparam int TIMEOUT_CYCLES = MAX_TXNS * TXN_CYCLES * 8 + 160;

    logic                             clk;
    logic                             rst;
    logic [PORTS-1:0]                 req;
    mem_cmd_t [PORTS-1:0]             cmd;
    logic [PORTS-1:0]                 ack;
    logic [PORTS-1:0][DATA_W-1:0]     rdata;

    logic [DATA_W-1:0]                ref_mem [MEM_WORDS];  // Reference copy of the scratch memory
    logic [PORTS-1:0][DATA_W-1:0]     exp_rdata;            // Result each client should get back
    logic [PORTS-1:0]                 ack_q;
    logic [PORTS-1:0]                 round_seen;           // Clients served in the current round
    logic                             rr_active;
    int                               errors = 0;
    int                               checks = 0;
    int                               cycle_count = 0;

    mem_hub #(.PORTS(PORTS), .ARB_TYPE(ARB_ROUND_ROBIN)) dut_i (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .cmd   (cmd),
        .ack   (ack),
        .rdata (rdata)
    );

    always #50 clk = ~clk;

    // Result of one command as the memory rules define it
    function automatic logic [DATA_W-1:0] expected_result(input op_e opcode,
            input logic [DATA_W-1:0] old_word, input logic [DATA_W-1:0] operand);
        case (opcode)
            OP_WRITE: return operand;
            OP_ADD:   return DATA_W'((32'(old_word) + 32'(operand)) % 65536);
            default:  return old_word;
        endcase
    endfunction

    always_comb begin
        for (int p = 0; p < PORTS; p++) begin
            exp_rdata[p] = expected_result(cmd[p].op, ref_mem[cmd[p].addr], cmd[p].data);
        end
    end

    // Model follows completions in the order the acks rise
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q      <= '0;
            round_seen <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                ref_mem[i] <= '0;
            end
        end else begin
            ack_q <= ack;
            for (int p = 0; p < PORTS; p++) begin
                if (ack[p] && !ack_q[p]) begin
                    checks++;
                    if (cmd[p].op != OP_READ) begin
                        ref_mem[cmd[p].addr] <= exp_rdata[p];  // Store follows the same rule
                    end
                    if (rr_active) begin
                        // A full round clears the set and the next one starts
                        if ((round_seen | (PORTS'(1) << p)) == '1) round_seen <= '0;
                        else round_seen <= round_seen | (PORTS'(1) << p);
                    end
                end
            end
        end
    end

    for (genvar p = 0; p < PORTS; p++) begin : g_check
        a_rdata: assert property (@(posedge clk) disable iff (rst)
            $rose(ack[p]) |-> rdata[p] == exp_rdata[p])
        else begin
            $display("** Error at %0t: rdata[%0d] expected %h, got %h", $time, p,
                     $sampled(exp_rdata[p]), $sampled(rdata[p]));
            errors++;
        end
        a_ack_rise: assert property (@(posedge clk) disable iff (rst)
            $rose(ack[p]) |-> $past(req[p]))
        else begin
            $display("Handshake error at %0t: ack[%0d] rose while req was low", $time, p);
            errors++;
        end
        a_ack_fall: assert property (@(posedge clk) disable iff (rst)
            $fell(ack[p]) |-> !$past(req[p]))
        else begin
            $display("Handshake error at %0t: ack[%0d] fell before req was seen low", $time, p);
            errors++;
        end
        a_rotation: assert property (@(posedge clk) disable iff (rst)
            rr_active && $rose(ack[p]) |-> !round_seen[p])
        else begin
            $display("Arbitration error at %0t: client %0d served twice in one round", $time, p);
            errors++;
        end
    end

    // One complete four-phase transaction entered and left 10 ns after an edge
    task automatic run_txn(input int p, input op_e opcode, input logic [ADDR_W-1:0] address,
                           input logic [DATA_W-1:0] wdata, input int hold);
        cmd[p].op   = opcode;
        cmd[p].addr = address;
        cmd[p].data = wdata;
        req[p]      = 1'b1;
        do begin
            @(posedge clk);
            #10;
        end while (!ack[p]);
        repeat (hold) begin  // Slow client keeps req up after ack
            @(posedge clk);
            #10;
        end
        req[p] = 1'b0;
        do begin
            @(posedge clk);
            #10;
        end while (ack[p]);
    endtask

    // Back-to-back random commands on a few shared addresses
    task automatic rr_client(input int p, input int count);
        op_e               opcode;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] wdata;
        for (int n = 0; n < count; n++) begin
            opcode  = op_e'($urandom_range(2));
            address = ADDR_W'($urandom_range(3));
            wdata   = DATA_W'($urandom);
            run_txn(p, opcode, address, wdata, 0);
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d (%s) finished with %0d errors", num, name, errors - err_before);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int err_before;
        void'($urandom(32'hc4d5));
        clk       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        cmd       = '0;
        rr_active = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;

        err_before = errors;
        assert (ack == '0) else begin
            $display("** Error at %0t: ack expected %h, got %h", $time, {PORTS{1'b0}}, ack);
            errors++;
        end
        for (int p = 0; p < PORTS; p++) begin
            run_txn(p, OP_READ, ADDR_W'($urandom), '0, 0);  // Cleared memory reads zero
        end
        report_test(1, "reset_reads", err_before);

        err_before = errors;
        run_txn(0, OP_WRITE, 4'd3, DATA_W'($urandom), 0);
        run_txn(2, OP_READ, 4'd3, '0, 0);
        run_txn(1, OP_WRITE, 4'd9, 16'hbeef, 0);
        run_txn(3, OP_READ, 4'd9, '0, 0);
        report_test(2, "write_read", err_before);

        err_before = errors;
        run_txn(1, OP_WRITE, 4'd5, 16'hfff0, 0);
        run_txn(2, OP_ADD, 4'd5, 16'h0025, 0);  // Sum wraps past the word width
        run_txn(3, OP_READ, 4'd5, '0, 0);
        run_txn(0, OP_ADD, 4'd7, DATA_W'($urandom), 0);
        report_test(3, "add_wrap", err_before);

        err_before = errors;
        fork
            run_txn(0, OP_ADD, 4'd5, 16'h0100, 4);  // Holds req four cycles after ack
            run_txn(1, OP_READ, 4'd5, '0, 0);
        join
        report_test(4, "handshake", err_before);

        err_before = errors;
        rr_active = 1'b1;
        fork
            rr_client(0, 5);
            rr_client(1, 5);
            rr_client(2, 5);
            rr_client(3, 5);
        join
        rr_active = 1'b0;
        report_test(5, "round_robin", err_before);

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src/mem_hub.sv
`timescale 1ns/1ns

module mem_hub import arb_pkg::*; #(
    parameter int   PORTS    = 4,
    parameter arb_e ARB_TYPE = ARB_ROUND_ROBIN
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [PORTS-1:0]             req,
    input  mem_cmd_t [PORTS-1:0]         cmd,
    output logic [PORTS-1:0]             ack,
    output logic [PORTS-1:0][DATA_W-1:0] rdata
);

    logic [PORTS-1:0]         arb_request;    // One pending bit per channel
    logic [PORTS-1:0]         arb_ack;        // Channel saw its own response
    logic [PORTS-1:0]         grant;
    logic                     grant_valid;
    logic [$clog2(PORTS)-1:0] grant_encoded;
    mem_rsp_t                 rsp;            // Broadcast to every channel

    arbiter #(.PORTS(PORTS), .ARB_TYPE(ARB_TYPE)) arbiter_i (
        .clk           (clk),
        .rst           (rst),
        .request       (arb_request),
        .acknowledge   (arb_ack),
        .grant         (grant),
        .grant_valid   (grant_valid),
        .grant_encoded (grant_encoded)
    );

    shared_mem #(.PORTS(PORTS)) shared_mem_i (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd),
        .grant_valid   (grant_valid),
        .grant_encoded (grant_encoded),
        .rsp           (rsp)
    );

    // Each client gets its own handshake channel
    for (genvar p = 0; p < PORTS; p++) begin : g_chan
        client_channel chan_i (
            .clk         (clk),
            .rst         (rst),
            .req         (req[p]),
            .ack         (ack[p]),
            .rdata       (rdata[p]),
            .grant_bit   (grant[p]),
            .rsp         (rsp),
            .arb_request (arb_request[p]),
            .arb_ack     (arb_ack[p])
        );
    end

endmodule

//--- src/shared_mem.sv
`timescale 1ns/1ns

module shared_mem import arb_pkg::*; #(
    parameter int PORTS = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  mem_cmd_t [PORTS-1:0]     cmd,
    input  logic                     grant_valid,
    input  logic [$clog2(PORTS)-1:0] grant_encoded,
    output mem_rsp_t                 rsp
);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    mem_state_e        state;
    mem_cmd_t          sel_cmd;
    logic [DATA_W-1:0] old_word;
    logic [DATA_W-1:0] result;
    logic              execute;
    logic [DATA_W-1:0] rsp_data;

    assign sel_cmd  = cmd[grant_encoded];  // Command of the granted client
    assign old_word = mem[sel_cmd.addr];

    // A grant is executed only once, on the first idle cycle it is seen
    assign execute = (state == MS_IDLE) && grant_valid;

    // Value returned to the client and, for stores, written back
    always_comb begin
        case (sel_cmd.op)
            OP_WRITE: result = sel_cmd.data;
            OP_ADD:   result = old_word + sel_cmd.data;  // Wraps at the word width
            default:  result = old_word;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MS_IDLE;
        end else begin
            case (state)
                MS_IDLE: if (execute) state <= MS_DONE;
                default: state <= MS_IDLE;  // Response shown for one cycle only
            endcase
        end
    end

    // Storage starts from all zeros after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (execute && sel_cmd.op != OP_READ) begin
            mem[sel_cmd.addr] <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (execute) begin
            rsp_data <= result;
        end
    end

    assign rsp.valid = (state == MS_DONE);
    assign rsp.data  = rsp_data;

    a_rsp_single: assert property (@(posedge clk) disable iff (rst)
        rsp.valid |=> !rsp.valid);

endmodule

//--- src/client_channel.sv
`timescale 1ns/1ns

module client_channel import arb_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    output logic              ack,
    output logic [DATA_W-1:0] rdata,
    input  logic              grant_bit,
    input  mem_rsp_t          rsp,
    output logic              arb_request,
    output logic              arb_ack
);

    chan_state_e state;
    logic        own_rsp;

    // The broadcast response is ours when we hold the grant
    assign own_rsp = rsp.valid && grant_bit;

    // Withdraw the request in the response cycle so the arbiter can move on
    assign arb_request = (state == CH_WAIT) && !own_rsp;
    assign arb_ack     = own_rsp;

    assign ack = (state == CH_ACK);  // High from the cycle after the response

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= CH_IDLE;
        end else begin
            case (state)
                CH_IDLE: if (req) state <= CH_WAIT;      // Client presented a command
                CH_WAIT: if (own_rsp) state <= CH_ACK;
                CH_ACK:  if (!req) state <= CH_IDLE;     // Client closed the handshake
                default: state <= CH_IDLE;
            endcase
        end
    end

    // Result word stays valid until the next response for this client
    always_ff @(posedge clk) begin
        if (state == CH_WAIT && own_rsp) begin
            rdata <= rsp.data;
        end
    end

    // Ack only rises for a client that kept req high until served
    a_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req));

endmodule

//--- src/arbiter.sv
`timescale 1ns/1ns

module arbiter import arb_pkg::*; #(
    parameter int   PORTS    = 4,
    parameter arb_e ARB_TYPE = ARB_ROUND_ROBIN
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [PORTS-1:0]         request,
    input  logic [PORTS-1:0]         acknowledge,
    output logic [PORTS-1:0]         grant,
    output logic                     grant_valid,
    output logic [$clog2(PORTS)-1:0] grant_encoded
);

    localparam int IDX_W = $clog2(PORTS);

    logic [PORTS-1:0] grant_reg, grant_next;
    logic             grant_valid_reg, grant_valid_next;
    logic [IDX_W-1:0] grant_encoded_reg, grant_encoded_next;
    logic [PORTS-1:0] mask_reg, mask_next;  // Ports still owed a turn this round

    // Plain encoder result over every pending port
    logic             req_valid;
    logic [IDX_W-1:0] req_index;
    logic [PORTS-1:0] req_onehot;

    // Same search restricted to ports after the last winner
    logic             masked_valid;
    logic [IDX_W-1:0] masked_index;
    logic [PORTS-1:0] masked_onehot;

    assign grant         = grant_reg;
    assign grant_valid   = grant_valid_reg;
    assign grant_encoded = grant_encoded_reg;

    priority_encoder #(.PORTS(PORTS)) plain_enc_i (
        .request_in (request),
        .valid      (req_valid),
        .index      (req_index),
        .onehot     (req_onehot)
    );

    priority_encoder #(.PORTS(PORTS)) masked_enc_i (
        .request_in (request & mask_reg),
        .valid      (masked_valid),
        .index      (masked_index),
        .onehot     (masked_onehot)
    );

    always_comb begin
        grant_next         = '0;
        grant_valid_next   = 1'b0;
        grant_encoded_next = '0;
        mask_next          = mask_reg;

        if (grant_valid_reg && !(|(grant_reg & acknowledge))) begin
            // Served port has not acknowledged yet so the grant stays put
            grant_next         = grant_reg;
            grant_valid_next   = 1'b1;
            grant_encoded_next = grant_encoded_reg;
        end else if (req_valid) begin
            grant_valid_next = 1'b1;
            if (ARB_TYPE == ARB_ROUND_ROBIN && masked_valid) begin
                grant_next         = masked_onehot;  // Next port in the rotation
                grant_encoded_next = masked_index;
                mask_next          = {PORTS{1'b1}} << (masked_index + 1);
            end else begin
                grant_next         = req_onehot;     // Lowest pending port
                grant_encoded_next = req_index;
                if (ARB_TYPE == ARB_ROUND_ROBIN) begin
                    // Wrap around and start a new round after this winner
                    mask_next = {PORTS{1'b1}} << (req_index + 1);
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant_reg         <= '0;
            grant_valid_reg   <= 1'b0;
            grant_encoded_reg <= '0;
            mask_reg          <= '0;
        end else begin
            grant_reg         <= grant_next;
            grant_valid_reg   <= grant_valid_next;
            grant_encoded_reg <= grant_encoded_next;
            mask_reg          <= mask_next;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && (grant_valid == (|grant)));

    // Grant moves only once the owning channel has seen its response
    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        grant_valid && !(|(grant & acknowledge)) |=> grant_valid && grant == $past(grant));

endmodule

//--- src/priority_encoder.sv
`timescale 1ns/1ns

module priority_encoder #(
    parameter int PORTS = 4
) (
    input  logic [PORTS-1:0]         request_in,
    output logic                     valid,
    output logic [$clog2(PORTS)-1:0] index,
    output logic [PORTS-1:0]         onehot
);

    localparam int IDX_W = $clog2(PORTS);

    // Any request at all makes the result meaningful
    assign valid = |request_in;

    // Two's complement trick isolates the lowest set bit
    assign onehot = request_in & (~request_in + 1'b1);

    // Scan from the top so the lowest set bit is the last one written
    always_comb begin
        index = '0;
        for (int i = PORTS - 1; i >= 0; i--) begin
            if (request_in[i]) begin
                index = IDX_W'(i);  // Lower bits override higher ones
            end
        end
    end

    initial begin
        // A single port still needs at least one index bit to be meaningful
        if (PORTS < 2) begin
            $error("priority_encoder needs PORTS of at least 2");
        end
    end

endmodule

//--- src/arb_pkg.sv
package arb_pkg;

    // Word and address widths shared by every block of the hub
    localparam int DATA_W    = 16;
    localparam int ADDR_W    = 4;
    localparam int MEM_WORDS = 2 ** ADDR_W;  // Sixteen words of scratch storage

    // Operations a client can ask the memory to perform
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_ADD   = 2'd2   // Read-modify-write, the new value is returned
    } op_e;

    // Grant policy of the arbiter
    typedef enum logic {
        ARB_PRIORITY    = 1'b0,  // Lowest pending index always wins
        ARB_ROUND_ROBIN = 1'b1   // Winner rotates through the pending ports
    } arb_e;

    // Command presented by a client, held stable while its req is high
    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_cmd_t;

    // Response broadcast by the memory to all channels
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } mem_rsp_t;

    // Handshake states of one client channel
    typedef enum logic [1:0] {
        CH_IDLE = 2'd0,
        CH_WAIT = 2'd1,  // Request pending at the arbiter
        CH_ACK  = 2'd2   // Result returned, waiting for req to drop
    } chan_state_e;

    // The memory either waits for a grant or presents a response
    typedef enum logic {
        MS_IDLE = 1'b0,
        MS_DONE = 1'b1
    } mem_state_e;

endpackage
